/* hdl/cache_pkg.sv */
package cache_pkg;

	// ----------------------------------------
	// Data types.
	// ----------------------------------------

	typedef logic [31:0]  word;
	typedef logic [15:0]  hword;
	typedef logic [127:0] line;
	typedef logic [15:0]  line_be;
	typedef logic [27:0]  line_ptr;

	// Byte offset bits dropped from a line address.
	localparam int line_offset_bits = $bits(word) - $bits(line_ptr);

	// Top two address bits select cached memory or IO space.
	typedef struct packed {
		logic [1:0]  io;
		logic [29:0] offset;
	} addr_bits;

	localparam logic [1:0] io_cached = 2'b00;

	// ----------------------------------------
	// Ring.
	// ----------------------------------------

	typedef logic [1:0] ttl_t;

	localparam ttl_t ttl_max = 2'b11;
	localparam ttl_t ttl_end = 2'b00;

	typedef struct packed {
		logic    read;
		logic    inval;
		logic    reply;
		ttl_t    ttl;
		line_ptr address;
		line     data;
	} ring_req;

	// Header fields only, as seen by the monitor.
	typedef struct packed {
		logic read;
		logic inval;
		logic reply;
		ttl_t ttl;
	} perf_sample;

	// ----------------------------------------
	// Counter register map.
	// ----------------------------------------

	typedef enum logic [3:0] {
		reg_reads,
		reg_writes,
		reg_read_range,
		reg_write_range,
		reg_ring_reads,
		reg_ring_invals,
		reg_ring_read_invals,
		reg_ring_replies,
		reg_ring_forwards,
		reg_ring_range,
		reg_io_reads,
		reg_io_writes
	} perf_reg;

endpackage

/* hdl/mem_port_if.sv */
`timescale 1ns/1ps

interface mem_port_if
	import cache_pkg::*;
#(
	parameter int addr_w = $bits(word)
);

	logic [addr_w-1:0] address;
	logic              read;
	logic              write;
	line               writedata;
	line_be            byteenable;
	logic              waitrequest;
	line               readdata;

	modport master (
		output address, read, write, writedata, byteenable,
		input  waitrequest, readdata
	);

	modport slave (
		input  address, read, write, writedata, byteenable,
		output waitrequest, readdata
	);

endinterface

/* hdl/perf_snoop.sv */
`timescale 1ns/1ps

module perf_snoop
	import cache_pkg::*;
(
	input  logic       clk,
	input  logic       rst_n,

	mem_port_if.slave  local_port,
	mem_port_if.master mem_port,

	input  logic       in_left_valid,
	input  ring_req    in_left,
	output logic       in_left_ready,

	output logic       out_left_valid,
	output ring_req    out_left,
	input  logic       out_left_ready,

	input  logic       in_right_valid,
	input  logic       in_right_ready,
	input  ring_req    in_right,

	output logic       snoop_left_fire,
	output logic       snoop_right_fire,
	output perf_sample snoop_left,
	output perf_sample snoop_right,
	output word        snoop_address
);

	// ----------------------------------------
	// Memory pass-through.
	// ----------------------------------------

	assign mem_port.address    = {local_port.address, {line_offset_bits{1'b0}}};
	assign mem_port.read       = local_port.read;
	assign mem_port.write      = local_port.write;
	assign mem_port.writedata  = local_port.writedata;
	assign mem_port.byteenable = local_port.byteenable;

	assign local_port.waitrequest = mem_port.waitrequest;
	assign local_port.readdata    = mem_port.readdata;

	assign snoop_address = mem_port.address;

	// ----------------------------------------
	// Ring taps.
	// ----------------------------------------

	assign out_left_valid = in_left_valid;
	assign out_left       = in_left;
	assign in_left_ready  = out_left_ready;

	assign snoop_left_fire  = in_left_valid && out_left_ready;
	assign snoop_right_fire = in_right_valid && in_right_ready;

	assign snoop_left  = '{in_left.read, in_left.inval, in_left.reply, in_left.ttl};
	assign snoop_right = '{in_right.read, in_right.inval, in_right.reply, in_right.ttl};

	// A stalled beat must wait for ready.
	left_valid_held: assert property (@(posedge clk) disable iff (!rst_n)
		in_left_valid && !out_left_ready |=> in_left_valid);

	right_valid_held: assert property (@(posedge clk) disable iff (!rst_n)
		in_right_valid && !in_right_ready |=> in_right_valid);

	mem_read_write_excl: assert property (@(posedge clk) disable iff (!rst_n)
		!(mem_port.read && mem_port.write));

endmodule

/* hdl/latency_range.sv */
`timescale 1ns/1ps

module latency_range
	import cache_pkg::*;
(
	input  logic clk,
	input  logic rst_n,

	input  logic clear,
	input  logic sample_valid,
	input  hword sample,

	output word  range
);

	hword min_lat, max_lat;

	// Zero in min_lat means nothing sampled yet.
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			min_lat <= '0;
			max_lat <= '0;
		end else if (clear) begin
			min_lat <= '0;
			max_lat <= '0;
		end else if (sample_valid) begin
			if (min_lat == '0 || sample < min_lat)
				min_lat <= sample;
			if (sample > max_lat)
				max_lat <= sample;
		end
	end

	assign range = {max_lat, min_lat};

	min_not_above_max: assert property (@(posedge clk) disable iff (!rst_n)
		min_lat != '0 |-> min_lat <= max_lat);

endmodule

/* hdl/perf_link.sv */
`timescale 1ns/1ps

module perf_link
	import cache_pkg::*;
(
	input  logic       clk,
	input  logic       rst_n,

	mem_port_if.slave  local_port,
	mem_port_if.master mem_port,

	input  logic       in_left_valid,
	input  ring_req    in_left,
	output logic       in_left_ready,

	output logic       out_left_valid,
	output ring_req    out_left,
	input  logic       out_left_ready,

	input  logic       in_right_valid,
	input  logic       in_right_ready,
	input  ring_req    in_right,

	input  logic       clear,
	input  perf_reg    address,
	output word        readdata
);

	logic snoop_left_fire, snoop_right_fire;
	logic mem_fire, cached, injected, returned;

	perf_sample snoop_left, snoop_right;
	word        snoop_address;
	addr_bits   snoop_bits;

	hword mem_cycles, mem_cycles_hold, ring_cycles;

	word reads, writes, io_reads, io_writes;
	word ring_reads, ring_invals, ring_read_invals, ring_replies, ring_forwards;
	word read_range, write_range, ring_range;

	perf_snoop snoop (.*);

	assign snoop_bits = snoop_address;
	assign cached     = snoop_bits.io == io_cached;
	assign mem_fire   = (mem_port.read || mem_port.write) && !mem_port.waitrequest;
	assign mem_cycles = mem_cycles_hold + hword'(1);

	assign injected = snoop_right_fire && snoop_right.ttl == ttl_max;
	assign returned = snoop_left_fire && snoop_left.ttl == ttl_end;

	// ----------------------------------------
	// Latency trackers.
	// ----------------------------------------

	latency_range read_lat (
		.clk, .rst_n, .clear,
		.sample_valid(mem_fire && cached && mem_port.read),
		.sample(mem_cycles),
		.range(read_range)
	);

	latency_range write_lat (
		.clk, .rst_n, .clear,
		.sample_valid(mem_fire && cached && mem_port.write),
		.sample(mem_cycles),
		.range(write_range)
	);

	latency_range ring_lat (
		.clk, .rst_n, .clear,
		.sample_valid(returned),
		.sample(ring_cycles),
		.range(ring_range)
	);

	// Held cycles of the current request, and cycles since last injection.
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			mem_cycles_hold <= '0;
			ring_cycles <= '0;
		end else begin
			if (mem_fire)
				mem_cycles_hold <= '0;
			else if (mem_port.read || mem_port.write)
				mem_cycles_hold <= mem_cycles;

			ring_cycles <= injected ? hword'(1) : ring_cycles + hword'(1);
		end
	end

	// ----------------------------------------
	// Event counters.
	// ----------------------------------------

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			reads <= '0;
			writes <= '0;
			io_reads <= '0;
			io_writes <= '0;
			ring_reads <= '0;
			ring_invals <= '0;
			ring_read_invals <= '0;
			ring_replies <= '0;
			ring_forwards <= '0;
		end else if (clear) begin
			reads <= '0;
			writes <= '0;
			io_reads <= '0;
			io_writes <= '0;
			ring_reads <= '0;
			ring_invals <= '0;
			ring_read_invals <= '0;
			ring_replies <= '0;
			ring_forwards <= '0;
		end else begin
			if (mem_fire) begin
				if (!cached && mem_port.write)
					io_writes <= io_writes + 1;
				else if (!cached)
					io_reads <= io_reads + 1;
				else if (mem_port.write)
					writes <= writes + 1;
				else
					reads <= reads + 1;
			end

			if (injected) begin
				if (snoop_right.read && snoop_right.inval)
					ring_read_invals <= ring_read_invals + 1;
				else if (snoop_right.read)
					ring_reads <= ring_reads + 1;
				else if (snoop_right.inval)
					ring_invals <= ring_invals + 1;
			end else if (snoop_right_fire)
				ring_forwards <= ring_forwards + 1;

			if (returned && snoop_left.reply)
				ring_replies <= ring_replies + 1;
		end
	end

	always_comb begin
		case (address)
			reg_reads:            readdata = reads;
			reg_writes:           readdata = writes;
			reg_read_range:       readdata = read_range;
			reg_write_range:      readdata = write_range;
			reg_ring_reads:       readdata = ring_reads;
			reg_ring_invals:      readdata = ring_invals;
			reg_ring_read_invals: readdata = ring_read_invals;
			reg_ring_replies:     readdata = ring_replies;
			reg_ring_forwards:    readdata = ring_forwards;
			reg_ring_range:       readdata = ring_range;
			reg_io_reads:         readdata = io_reads;
			reg_io_writes:        readdata = io_writes;
			default:              readdata = '0;
		endcase
	end

endmodule

/* hdl/ring_perf_monitor.sv */
`timescale 1ns/1ps

module ring_perf_monitor
	import cache_pkg::*;
(
	input  logic       clk,
	input  logic       rst_n,

	input  logic       in_left_valid,
	input  ring_req    in_left,
	output logic       in_left_ready,

	output logic       out_left_valid,
	output ring_req    out_left,
	input  logic       out_left_ready,

	input  logic       in_right_valid,
	input  logic       in_right_ready,
	input  ring_req    in_right,

	input  line_ptr    local_address,
	input  logic       local_read,
	input  logic       local_write,
	input  line        local_writedata,
	input  line_be     local_byteenable,
	output logic       local_waitrequest,
	output line        local_readdata,

	input  logic       mem_waitrequest,
	input  line        mem_readdata,
	output word        mem_address,
	output logic       mem_read,
	output logic       mem_write,
	output line        mem_writedata,
	output line_be     mem_byteenable,

	input  logic       clear,
	input  logic [3:0] address,
	output word        readdata
);

	mem_port_if #(.addr_w($bits(line_ptr))) local_if ();
	mem_port_if mem_if ();

	// Cache side.
	assign local_if.address    = local_address;
	assign local_if.read       = local_read;
	assign local_if.write      = local_write;
	assign local_if.writedata  = local_writedata;
	assign local_if.byteenable = local_byteenable;
	assign local_waitrequest   = local_if.waitrequest;
	assign local_readdata      = local_if.readdata;

	// Memory bus side.
	assign mem_if.waitrequest = mem_waitrequest;
	assign mem_if.readdata    = mem_readdata;
	assign mem_address        = mem_if.address;
	assign mem_read           = mem_if.read;
	assign mem_write          = mem_if.write;
	assign mem_writedata      = mem_if.writedata;
	assign mem_byteenable     = mem_if.byteenable;

	perf_link perf_link_i (
		.clk, .rst_n,
		.local_port(local_if.slave),
		.mem_port(mem_if.master),
		.in_left_valid, .in_left, .in_left_ready,
		.out_left_valid, .out_left, .out_left_ready,
		.in_right_valid, .in_right_ready, .in_right,
		.clear,
		.address(perf_reg'(address)),
		.readdata
	);

endmodule

/* verification/ring_perf_monitor_tb.sv */
`timescale 1ns/1ps

module ring_perf_monitor_tb
	import cache_pkg::*;
();

	localparam string golden_path   = "verification/ring_perf_golden.txt";
	localparam int    cycles_per_op = 64;

	logic       clk, rst_n;
	logic       in_left_valid, in_left_ready, out_left_valid, out_left_ready;
	logic       in_right_valid, in_right_ready;
	ring_req    in_left, out_left, in_right;
	line_ptr    local_address;
	logic       local_read, local_write, local_waitrequest;
	line        local_writedata, local_readdata, mem_readdata, mem_writedata;
	line_be     local_byteenable, mem_byteenable;
	logic       mem_waitrequest, mem_read, mem_write;
	word        mem_address, readdata;
	logic       clear;
	logic [3:0] address;

	word rand_state = 32'h4258_691a;
	int  errors = 0;
	int  checks = 0;
	int  watchdog_cycles = 0;

	ring_perf_monitor ring_perf_monitor_i (.*);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// Xorshift32 step.
	function automatic word random_word();
		rand_state = rand_state ^ (rand_state << 13);
		rand_state = rand_state ^ (rand_state >> 17);
		rand_state = rand_state ^ (rand_state << 5);
		return rand_state;
	endfunction

	function automatic ring_req random_req(input logic read, input logic inval,
			input logic reply, input ttl_t ttl);
		ring_req req;
		req.read    = read;
		req.inval   = inval;
		req.reply   = reply;
		req.ttl     = ttl;
		req.address = line_ptr'(random_word());
		req.data    = {random_word(), random_word(), random_word(), random_word()};
		return req;
	endfunction

	task automatic expect_true(input logic ok, input string what);
		checks++;
		assert (ok) else begin
			errors++;
			$display("Fail at %0t ns: %s", $time, what);
		end
	endtask

	// ----------------------------------------
	// Memory and ring operations.
	// ----------------------------------------

	task automatic mem_access(input logic is_write, input logic [1:0] io,
			input int wait_cycles);
		word     r;
		line_ptr addr;
		line     data;
		r    = random_word();
		addr = {io, r[25:0]};
		data = {random_word(), random_word(), random_word(), random_word()};
		@(posedge clk);
		local_address    <= addr;
		local_read       <= !is_write;
		local_write      <= is_write;
		local_writedata  <= data;
		local_byteenable <= '1;
		mem_readdata     <= ~data;
		mem_waitrequest  <= wait_cycles > 0;
		for (int i = 1; i <= wait_cycles; i++) begin
			@(negedge clk);
			expect_true(local_waitrequest, "memory waitrequest pass-through");
			@(posedge clk);
			mem_waitrequest <= i < wait_cycles;
		end
		// Transfer cycle.
		@(negedge clk);
		expect_true(mem_address == {addr, 4'h0}, "memory address pass-through");
		expect_true(mem_read == !is_write && mem_write == is_write, "memory command pass-through");
		expect_true(mem_writedata == data && mem_byteenable == '1, "memory write pass-through");
		expect_true(local_readdata == ~data && !local_waitrequest, "memory read pass-through");
		@(posedge clk);
		local_read      <= 1'b0;
		local_write     <= 1'b0;
		mem_waitrequest <= 1'b0;
	endtask

	task automatic inject_req(input logic read, input logic inval);
		@(posedge clk);
		in_right       <= random_req(read, inval, 1'b0, ttl_max);
		in_right_valid <= 1'b1;
		in_right_ready <= 1'b1;
		@(posedge clk);
		in_right_valid <= 1'b0;
		in_right_ready <= 1'b0;
	endtask

	// Random back-pressure before the beat is taken.
	task automatic forward_req(input ttl_t ttl);
		word r;
		int  stall;
		r     = random_word();
		stall = int'(r % 3);
		@(posedge clk);
		in_right       <= random_req(r[4], r[5], r[6], ttl);
		in_right_valid <= 1'b1;
		in_right_ready <= stall == 0;
		for (int i = 1; i <= stall; i++) begin
			@(posedge clk);
			in_right_ready <= i == stall;
		end
		@(posedge clk);
		in_right_valid <= 1'b0;
		in_right_ready <= 1'b0;
	endtask

	// Accepted delay cycles after the edge that took the last injection.
	task automatic return_req(input logic reply, input int delay);
		ring_req beat;
		int      stall;
		beat  = random_req(1'b0, 1'b0, reply, ttl_end);
		stall = delay > 1 ? 1 : 0;
		repeat (delay - 1 - stall) @(posedge clk);
		in_left        <= beat;
		in_left_valid  <= 1'b1;
		out_left_ready <= stall == 0;
		// One stalled cycle on the left when the delay leaves room.
		if (stall > 0) begin
			@(negedge clk);
			expect_true(out_left_valid && !in_left_ready, "left ring back-pressure");
			@(posedge clk);
			out_left_ready <= 1'b1;
		end
		@(negedge clk);
		expect_true(out_left_valid && out_left == beat && in_left_ready, "left ring pass-through");
		@(posedge clk);
		in_left_valid <= 1'b0;
	endtask

	task automatic clear_counters();
		@(posedge clk);
		clear <= 1'b1;
		@(posedge clk);
		clear <= 1'b0;
	endtask

	task automatic check_reg(input int reg_index, input word expected);
		@(posedge clk);
		address <= 4'(reg_index);
		@(negedge clk);
		checks++;
		assert (readdata == expected) else begin
			errors++;
			$display("Fail at %0t ns: register %0d reads %h, expected %h",
				$time, reg_index, readdata, expected);
		end
	endtask

	// ----------------------------------------
	// Golden file replay.
	// ----------------------------------------

	initial begin
		int               fd;
		int               code;
		int               line_count;
		int               arg_a;
		word              arg_b;
		string            op;
		logic [8*256-1:0] rest;

		rst_n <= 1'b0;
		in_left_valid <= 1'b0;
		in_left <= '0;
		out_left_ready <= 1'b1;
		in_right_valid <= 1'b0;
		in_right_ready <= 1'b0;
		in_right <= '0;
		local_address <= '0;
		local_read <= 1'b0;
		local_write <= 1'b0;
		local_writedata <= '0;
		local_byteenable <= '0;
		mem_waitrequest <= 1'b0;
		mem_readdata <= '0;
		clear <= 1'b0;
		address <= '0;
		repeat (8) @(posedge clk);
		rst_n <= 1'b1;

		line_count = 0;
		fd = $fopen(golden_path, "r");
		if (fd == 0) begin
			errors++;
			$display("Could not open %s, nothing was replayed", golden_path);
		end else begin
			while ($fgets(rest, fd) != 0)
				line_count++;
			$fclose(fd);
			watchdog_cycles = line_count * cycles_per_op;
			fd = $fopen(golden_path, "r");
			while ($fscanf(fd, "%s", op) == 1) begin
				case (op)
					"#":         code = $fgets(rest, fd);
					"mem_read":  begin
						code = $fscanf(fd, "%d %d", arg_a, arg_b);
						mem_access(1'b0, arg_a[1:0], int'(arg_b));
					end
					"mem_write": begin
						code = $fscanf(fd, "%d %d", arg_a, arg_b);
						mem_access(1'b1, arg_a[1:0], int'(arg_b));
					end
					"inject":    begin
						code = $fscanf(fd, "%d %d", arg_a, arg_b);
						inject_req(arg_a[0], arg_b[0]);
					end
					"forward":   begin
						code = $fscanf(fd, "%d", arg_a);
						forward_req(ttl_t'(arg_a));
					end
					"return":    begin
						code = $fscanf(fd, "%d %d", arg_a, arg_b);
						return_req(arg_a[0], int'(arg_b));
					end
					"clear":     clear_counters();
					"check":     begin
						code = $fscanf(fd, "%d %h", arg_a, arg_b);
						check_reg(arg_a, arg_b);
					end
					default:     begin
						errors++;
						$display("Unknown operation %s in the golden file", op);
					end
				endcase
			end
			$fclose(fd);
		end

		$display("Replay done: %0d checks, %0d errors", checks, errors);
		if (errors == 0)
			$display("*** TEST PASSED ***");
		else
			$display("*** TEST FAILED ***");
		$finish;
	end

	// Watchdog armed once the golden file is sized.
	initial begin
		wait (watchdog_cycles > 0);
		repeat (watchdog_cycles) @(posedge clk);
		$display("Timeout after %0d cycles, the replay did not finish", watchdog_cycles);
		$display("*** TEST FAILED ***");
		$finish;
	end

endmodule

/* verification/ring_perf_golden.txt */
# mem_read/mem_write io wait | inject read inval | forward ttl | return reply delay
# check register_index expected_hex | clear
mem_read 0 0
mem_read 0 3
mem_write 0 2
mem_write 0 5
mem_read 2 4
mem_write 1 0
mem_write 3 1
check 0 00000002
check 1 00000002
check 2 00040001
check 3 00060003
check 10 00000001
check 11 00000002
inject 1 0
return 1 5
inject 0 1
return 0 9
inject 1 1
return 1 3
forward 1
forward 2
forward 0
check 4 00000001
check 5 00000001
check 6 00000001
check 7 00000002
check 8 00000003
check 9 00090003
clear
check 0 00000000
check 2 00000000
check 3 00000000
check 7 00000000
check 8 00000000
check 9 00000000
check 11 00000000
mem_read 0 1
mem_write 2 0
inject 0 1
return 1 2
check 0 00000001
check 2 00020002
check 11 00000001
check 5 00000001
check 7 00000001
check 9 00020002
check 4 00000000

/* ring_perf_monitor.f */
hdl/cache_pkg.sv
hdl/mem_port_if.sv
hdl/perf_snoop.sv
hdl/latency_range.sv
hdl/perf_link.sv
hdl/ring_perf_monitor.sv
verification/ring_perf_monitor_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the ring_perf_monitor testbench with Verilator.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f ring_perf_monitor.f \
	--top-module ring_perf_monitor_tb -Mdir obj_dir
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

output=$(./obj_dir/Vring_perf_monitor_tb)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if echo "$output" | grep -qF "*** TEST PASSED ***"; then
	exit 0
fi
exit 1
